// ==== Bender.yml ====
package:
  name: cap

export_include_dirs:
  - .

sources:
  - cap_pkg.sv
  - cap_burst_if.sv
  - cap_beat_if.sv
  - cap_word_fifo.sv
  - cap_wr_ctrl.sv
  - cap_addr_gen.sv
  - cap_skid_buf.sv
  - cap_writer_top.sv
  - target: test
    files:
      - cap_tb_clk.sv
      - cap_asserts.sv
      - cap_tb.sv

// ==== cap.f ====
+incdir+.
cap_pkg.sv
cap_burst_if.sv
cap_beat_if.sv
cap_word_fifo.sv
cap_wr_ctrl.sv
cap_addr_gen.sv
cap_skid_buf.sv
cap_writer_top.sv
cap_tb_clk.sv
cap_asserts.sv
cap_tb.sv

// ==== cap_addr_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module cap_addr_gen import cap_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    cap_burst_if.gen  bus,
    output logic      o_buf_wrap,
    output cap_addr_t o_last_write_addr
);

    logic      first_load;  // no capture since reset yet
    cap_addr_t addr_q;
    cap_addr_t base_q;
    cap_addr_t end_q;       // base plus size, first byte past the buffer
    cap_addr_t next_addr;

    assign next_addr = addr_q + cap_addr_t'({bus.adv_words, 2'b00});  // four bytes per word

    assign bus.addr          = addr_q;
    assign bus.words_to_end  = (end_q - addr_q) >> 2;
    assign o_last_write_addr = addr_q;  // next free word

    always_ff @(posedge clk) begin
        if (!reset) begin
            first_load <= 1'b1;
            addr_q     <= '0;
            o_buf_wrap <= 1'b0;
        end else if (bus.load) begin
            // later captures continue after the previous one
            if (first_load) begin
                addr_q <= bus.buf_start;
            end
            first_load <= 1'b0;
        end else if (bus.advance) begin
            if (next_addr >= end_q) begin
                addr_q     <= base_q;
                o_buf_wrap <= 1'b1;     // sticky until reset
            end else begin
                addr_q <= next_addr;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus.load) begin
            base_q <= bus.buf_start;
            end_q  <= bus.buf_start + bus.buf_size;
        end
    end

endmodule

`default_nettype wire

// ==== cap_asserts.sv ====
`include "cap_config.svh"

`timescale 1ns/10ps
`default_nettype none

module cap_asserts import cap_pkg::*; (
    input logic      clk,
    input logic      reset,
    input logic      i_waitrequest,
    input logic      i_write,
    input cap_addr_t i_address,
    input cap_word_t i_writedata,
    input cap_bcnt_t i_burstcount,
    input logic      i_done
);

    // a stalled beat keeps its command and data
    property hold_under_stall;
        @(posedge clk) disable iff (!reset)
        (i_write && i_waitrequest) |=>
            (i_write && $stable(i_address) && $stable(i_burstcount) && $stable(i_writedata));
    endproperty

    property burst_in_range;
        @(posedge clk) disable iff (!reset)
        i_write |-> (i_burstcount >= 16'd1 && i_burstcount <= `CAP_MAX_BURST);
    endproperty

    property done_single_cycle;
        @(posedge clk) disable iff (!reset)
        i_done |=> !i_done;
    endproperty

    assert property (hold_under_stall)
        else $error("avalon command changed while waitrequest was high");
    assert property (burst_in_range)
        else $error("burstcount outside 1 to max burst");
    assert property (done_single_cycle)
        else $error("done strobe longer than one cycle");

endmodule

`default_nettype wire

// ==== cap_beat_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface cap_beat_if import cap_pkg::*; ();

    logic      valid;
    logic      ready;
    cap_addr_t address;     // burst start, same on every beat
    cap_bcnt_t burstcount;
    cap_word_t data;

    // a beat moves when valid and ready are both high
    modport src (
        output valid, address, burstcount, data,
        input  ready
    );

    modport snk (
        input  valid, address, burstcount, data,
        output ready
    );

endinterface

`default_nettype wire

// ==== cap_burst_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface cap_burst_if import cap_pkg::*; ();

    // from the control fsm
    logic      load;            // one-cycle pulse at capture start
    cap_addr_t buf_start;
    cap_addr_t buf_size;
    logic      advance;         // burst fully issued
    cap_bcnt_t adv_words;       // size of that burst

    // from the address generator, valid the cycle after load or advance
    cap_addr_t addr;            // start of current burst
    cap_addr_t words_to_end;    // words left, kept at address width

    modport ctrl (
        output load, buf_start, buf_size, advance, adv_words,
        input  addr, words_to_end
    );

    modport gen (
        input  load, buf_start, buf_size, advance, adv_words,
        output addr, words_to_end
    );

endinterface

`default_nettype wire

// ==== cap_config.svh ====
`ifndef CAP_CONFIG_SVH
`define CAP_CONFIG_SVH

`default_nettype none

// data word width in bits
`define CAP_DW 32

// byte address width
`define CAP_AW 32

// packet word fifo entries
`define CAP_FIFO_DEPTH 256

`define CAP_MAX_BURST 4     // words per avalon burst, upper bound

`define CAP_HDR_WORDS 4     // seconds, nanoseconds, length, length

`default_nettype wire

`endif

// ==== cap_pkg.sv ====
`include "cap_config.svh"

`default_nettype none

package cap_pkg;

    // bus payloads
    typedef logic [`CAP_DW-1:0] cap_word_t;
    typedef logic [`CAP_AW-1:0] cap_addr_t;    // byte address

    typedef logic [15:0] cap_len_t;            // length in words
    typedef logic [15:0] cap_bcnt_t;           // avalon burstcount

    // fill level, one bit wider than the pointers
    typedef logic [8:0] cap_level_t;

    // write engine states
    typedef enum logic [2:0] {
        IDLE,
        PREP,
        HEADER,
        PAYLOAD,
        DONE
    } cap_state_t;

endpackage

`default_nettype wire

// ==== cap_skid_buf.sv ====
`timescale 1ns/10ps
`default_nettype none

module cap_skid_buf import cap_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    cap_beat_if.snk in_beat,
    cap_beat_if.src out_beat
);

    logic      out_valid, skid_valid;
    cap_addr_t out_addr, skid_addr;
    cap_bcnt_t out_bcnt, skid_bcnt;
    cap_word_t out_data, skid_data;
    logic      out_free;

    assign out_free      = !out_valid || out_beat.ready;
    assign in_beat.ready = !skid_valid;     // registered ready

    assign out_beat.valid      = out_valid;
    assign out_beat.address    = out_addr;
    assign out_beat.burstcount = out_bcnt;
    assign out_beat.data       = out_data;

    always_ff @(posedge clk) begin
        if (!reset) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (out_free) begin
            out_valid  <= skid_valid || in_beat.valid;
            skid_valid <= 1'b0;             // skid drains first
        end else if (in_beat.valid && !skid_valid) begin
            skid_valid <= 1'b1;             // output stalled, park the beat
        end
    end

    always_ff @(posedge clk) begin
        if (out_free) begin
            out_addr <= skid_valid ? skid_addr : in_beat.address;
            out_bcnt <= skid_valid ? skid_bcnt : in_beat.burstcount;
            out_data <= skid_valid ? skid_data : in_beat.data;
        end else if (in_beat.valid && !skid_valid) begin
            skid_addr <= in_beat.address;
            skid_bcnt <= in_beat.burstcount;
            skid_data <= in_beat.data;
        end
    end

endmodule

`default_nettype wire

// ==== cap_tb.sv ====
`include "cap_config.svh"

`timescale 1ns/10ps
`default_nettype none

module cap_tb import cap_pkg::*; ();

    localparam int        CLK_NS   = 40;
    localparam int        N_CAPS   = 6;
    localparam int        STALL_X  = 8;               // worst-case cycles per beat
    localparam cap_addr_t BUF_BASE = 32'h0000_1000;
    localparam cap_addr_t BUF_SIZE = 32'h0000_0100;   // 64 words

    logic      clk, reset;
    cap_word_t i_pkt_data, i_seconds, i_nanoseconds;
    logic      i_pkt_push, i_start, i_waitrequest;
    cap_len_t  i_pkt_words;
    cap_addr_t i_buf_start, i_buf_size;
    logic      o_fifo_full, o_done, o_buf_wrap, o_write;
    cap_addr_t o_last_write_addr, o_address;
    cap_word_t o_writedata;
    cap_bcnt_t o_burstcount;

    // third capture wraps, fifth fills the whole buffer, last one fills the fifo
    int        pkt_len [N_CAPS] = '{10, 20, 30, 3, 60, 256};
    logic      stall_on [N_CAPS] = '{1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1};
    integer    seed = 32'h1da0;
    logic      stall_en;
    cap_word_t mem [cap_addr_t];        // slave memory, keyed by byte address
    cap_word_t exp_mem [cap_addr_t];
    cap_word_t pkt_q [$];
    logic      exp_wrap;
    cap_addr_t exp_next;
    int        start_count, done_count;
    cap_addr_t burst_addr;
    cap_bcnt_t burst_len;
    int        beat_idx;
    string     cur_test;

    cap_tb_clk #(.PERIOD_NS(CLK_NS), .RESET_CYCLES(10)) clk_i (.clk(clk), .reset(reset));

    cap_writer_top dut_i (.*);

    bind cap_writer_top cap_asserts asserts_i (
        .clk           (clk),
        .reset         (reset),
        .i_waitrequest (i_waitrequest),
        .i_write       (o_write),
        .i_address     (o_address),
        .i_writedata   (o_writedata),
        .i_burstcount  (o_burstcount),
        .i_done        (o_done)
    );

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s %s: expected %h, actual %h",
                     cur_test, name, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // expected image of one capture, returns the next free address
    function automatic cap_addr_t expect_capture(input cap_addr_t start, input cap_word_t sec,
                                                 input cap_word_t nsec, input int nwords);
        cap_addr_t a;
        cap_word_t w;
        int        i;
        a = start;
        for (i = 0; i < nwords + `CAP_HDR_WORDS; i++) begin
            case (i)
                0:       w = sec;
                1:       w = nsec;
                2, 3:    w = cap_word_t'(nwords) * 4;  // length in bytes
                default: w = pkt_q[i - `CAP_HDR_WORDS];
            endcase
            exp_mem[a] = w;
            a = a + 4;
            if (a == BUF_BASE + BUF_SIZE) begin
                a = BUF_BASE;
                exp_wrap = 1'b1;
            end
        end
        return a;
    endfunction

    // avalon slave with random waitrequest
    always @(posedge clk) begin
        if (!reset) begin
            i_waitrequest <= 1'b0;
            beat_idx = 0;
        end else begin
            i_waitrequest <= stall_en && ($random(seed) & 1);
            if (o_write && !i_waitrequest) begin
                if (beat_idx == 0) begin
                    burst_addr = o_address;
                    burst_len  = o_burstcount;
                    check_value("burst of 1 to 4 words", 1,
                                o_burstcount >= 1 && o_burstcount <= `CAP_MAX_BURST);
                    check_value("burst inside buffer", 1, o_address >= BUF_BASE &&
                                o_address + 4 * o_burstcount <= BUF_BASE + BUF_SIZE);
                end else begin
                    check_value("burst address held", burst_addr, o_address);
                end
                mem[burst_addr + 4 * beat_idx] = o_writedata;   // consecutive words
                beat_idx = (beat_idx + 1 == burst_len) ? 0 : beat_idx + 1;
            end
        end
    end

    // compare after every done pulse
    always @(posedge clk) begin
        if (reset && o_done) begin
            done_count = done_count + 1;
            check_value("one done per start", start_count, done_count);
            check_value("image size", exp_mem.num(), mem.num());
            foreach (exp_mem[a]) begin
                check_value($sformatf("word at %h written", a), 1, mem.exists(a));
                check_value($sformatf("word at %h", a), exp_mem[a], mem[a]);
            end
            check_value("next free address", exp_next, o_last_write_addr);
            check_value("wrap flag", exp_wrap, o_buf_wrap);
        end
    end

    initial begin
        cap_addr_t start_addr;
        cap_word_t sec, nsec;
        cap_word_t word;
        int        n;
        int        extra;
        int        k;
        int        j;
        i_pkt_data    = '0;
        i_pkt_push    = 1'b0;
        i_start       = 1'b0;
        i_pkt_words   = '0;
        i_buf_start   = BUF_BASE;
        i_buf_size    = BUF_SIZE;
        i_seconds     = '0;
        i_nanoseconds = '0;
        i_waitrequest = 1'b0;
        stall_en      = 1'b0;
        exp_wrap      = 1'b0;
        start_count   = 0;
        done_count    = 0;
        cur_test      = "reset";
        start_addr    = BUF_BASE;     // first capture begins at the base
        wait (reset === 1'b1);
        for (k = 0; k < N_CAPS; k++) begin
            n        = pkt_len[k];
            extra    = (n >= `CAP_FIFO_DEPTH) ? 4 : 0;  // pushes into a full fifo, dropped
            cur_test = $sformatf("capture %0d", k);
            sec      = 32'h5000_0000 + k;
            nsec     = 32'd1000 * k + 32'd7;
            @(posedge clk);
            stall_en <= stall_on[k];
            pkt_q.delete();
            for (j = 0; j < n + extra; j++) begin
                word = {8'hc0 + 8'(k), 8'h00, 16'(j)};
                if (j < n) begin
                    pkt_q.push_back(word);
                end
                i_pkt_push <= 1'b1;
                i_pkt_data <= word;
                @(posedge clk);
            end
            exp_next = expect_capture(start_addr, sec, nsec, n);
            start_count = start_count + 1;
            i_pkt_push    <= 1'b0;
            i_start       <= 1'b1;
            i_pkt_words   <= cap_len_t'(n);
            i_seconds     <= sec;
            i_nanoseconds <= nsec;
            @(posedge clk);
            check_value("fifo full flag", n >= `CAP_FIFO_DEPTH, o_fifo_full);
            i_start       <= 1'b0;
            i_seconds     <= ~sec;    // must not reach the header
            i_nanoseconds <= ~nsec;
            wait (done_count == start_count);
            start_addr = exp_next;
        end
        repeat (20) @(posedge clk);
        if (done_count == start_count) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            $display("done pulses %0d do not match %0d starts", done_count, start_count);
            $display("ERRORS FOUND");
            $fatal(1, "extra done pulse after the last capture");
        end
    end

    // watchdog sized from the packet lengths
    initial begin
        int total;
        total = 0;
        foreach (pkt_len[i]) begin
            total += (pkt_len[i] + `CAP_HDR_WORDS) * STALL_X + pkt_len[i] + 4;
        end
        #((total + 60) * CLK_NS);
        $display("timeout after %0d cycles, a capture never finished", total + 60);
        $display("ERRORS FOUND");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// ==== cap_tb_clk.sv ====
`timescale 1ns/10ps
`default_nettype none

module cap_tb_clk #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // active low, released on a rising edge
    initial begin
        reset = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== cap_word_fifo.sv ====
`include "cap_config.svh"

`timescale 1ns/10ps
`default_nettype none

module cap_word_fifo import cap_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       i_push,
    input  cap_word_t  i_data,
    input  logic       i_pop,
    output cap_word_t  o_data,
    output logic       o_empty,
    output logic       o_full,
    output cap_level_t o_level
);

    localparam int PTR_W = $clog2(`CAP_FIFO_DEPTH);

    cap_word_t        mem [`CAP_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             push_ok;
    logic             pop_ok;

    assign push_ok = i_push && !o_full;     // pushes into a full fifo are lost
    assign pop_ok  = i_pop && !o_empty;

    assign o_empty = (o_level == '0);
    assign o_full  = (o_level == cap_level_t'(`CAP_FIFO_DEPTH));

    always_ff @(posedge clk) begin
        if (!reset) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            o_level <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;    // depth is a power of two, wraps by itself
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push_ok && !pop_ok) begin
                o_level <= o_level + 1'b1;
            end else if (pop_ok && !push_ok) begin
                o_level <= o_level - 1'b1;
            end
        end
    end

    // storage and registered read port
    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= i_data;
        end
        if (pop_ok) begin
            o_data <= mem[rd_ptr];  // holds until the next pop
        end
    end

endmodule

`default_nettype wire

// ==== cap_wr_ctrl.sv ====
`include "cap_config.svh"

`timescale 1ns/10ps
`default_nettype none

module cap_wr_ctrl import cap_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       i_start,
    input  cap_len_t   i_pkt_words,
    input  cap_addr_t  i_buf_start,
    input  cap_addr_t  i_buf_size,
    input  cap_word_t  i_seconds,
    input  cap_word_t  i_nanoseconds,
    input  cap_word_t  i_fifo_data,
    input  logic       i_fifo_empty,
    input  cap_level_t i_fifo_level,
    output logic       o_fifo_rd,
    output logic       o_done,
    cap_burst_if.ctrl  bus,
    cap_beat_if.src    beat,
    input  logic       i_beat_accept
);

    cap_state_t  state, state_next;
    cap_len_t    pkt_words_q;
    cap_word_t   seconds_q, nanoseconds_q;
    cap_len_t    hdr_left, pay_left;    // words not yet given to a burst
    logic [16:0] acc_left;              // beats still to be accepted on avalon
    logic [1:0]  hdr_idx;
    logic        burst_on;
    cap_bcnt_t   burst_len, beats_left, next_len;
    logic        beat_valid_q, from_fifo_q;
    cap_addr_t   beat_addr_q;
    cap_bcnt_t   beat_bcnt_q;
    cap_word_t   hdr_word_q, hdr_word;
    logic        size_hdr, size_pay, beat_go, issue, last_accept;

    // min of words left, room to buffer end and max burst
    function automatic cap_bcnt_t burst_words(input cap_addr_t left, input cap_addr_t to_end);
        cap_addr_t n;
        n = (left < to_end) ? left : to_end;
        if (n > `CAP_MAX_BURST) begin
            n = `CAP_MAX_BURST;
        end
        return cap_bcnt_t'(n);
    endfunction

    assign next_len = (state == PAYLOAD) ? burst_words(cap_addr_t'(pay_left), bus.words_to_end)
                                         : burst_words(cap_addr_t'(hdr_left), bus.words_to_end);

    assign size_hdr = !burst_on && (state == PREP || state == HEADER) && (hdr_left != '0);
    assign size_pay = !burst_on && (state == PAYLOAD) && (pay_left != '0)
                      && (i_fifo_level >= next_len);   // whole burst must be in the fifo

    assign beat_go     = !beat_valid_q || beat.ready;   // output slot free this cycle
    assign issue       = burst_on && beat_go && (state == HEADER || !i_fifo_empty);
    assign last_accept = i_beat_accept && (acc_left == 17'd1);

    assign o_fifo_rd = issue && (state == PAYLOAD);
    assign o_done    = (state == DONE);

    assign bus.load      = (state == IDLE) && i_start;
    assign bus.buf_start = i_buf_start;
    assign bus.buf_size  = i_buf_size;
    assign bus.advance   = issue && (beats_left == 16'd1);
    assign bus.adv_words = burst_len;

    // fifo output register keeps the word stable while the beat stalls
    assign beat.valid      = beat_valid_q;
    assign beat.address    = beat_addr_q;
    assign beat.burstcount = beat_bcnt_q;
    assign beat.data       = from_fifo_q ? i_fifo_data : hdr_word_q;

    always_comb begin
        case (hdr_idx)
            2'd0:    hdr_word = seconds_q;
            2'd1:    hdr_word = nanoseconds_q;
            default: hdr_word = cap_word_t'(pkt_words_q) << 2;  // bytes, written twice
        endcase
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (i_start) begin
                    state_next = PREP;
                end
            end
            PREP:    state_next = HEADER;
            HEADER: begin
                if (last_accept) begin
                    state_next = DONE;
                end else if (!burst_on && hdr_left == '0) begin
                    state_next = PAYLOAD;
                end
            end
            PAYLOAD: begin
                if (last_accept) begin
                    state_next = DONE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            state        <= IDLE;
            burst_on     <= 1'b0;
            beats_left   <= '0;
            hdr_left     <= '0;
            pay_left     <= '0;
            acc_left     <= '0;
            hdr_idx      <= '0;
            beat_valid_q <= 1'b0;
        end else begin
            state <= state_next;
            if (i_beat_accept && acc_left != '0) begin
                acc_left <= acc_left - 1'b1;
            end
            if (bus.load) begin
                hdr_left <= cap_len_t'(`CAP_HDR_WORDS);
                pay_left <= i_pkt_words;
                acc_left <= 17'(i_pkt_words) + 17'(`CAP_HDR_WORDS);
                hdr_idx  <= '0;
            end
            if (size_hdr || size_pay) begin
                burst_on   <= 1'b1;
                beats_left <= next_len;
                if (size_hdr) begin
                    hdr_left <= hdr_left - next_len;
                end else begin
                    pay_left <= pay_left - next_len;
                end
            end else if (issue) begin
                beats_left <= beats_left - 1'b1;
                if (beats_left == 16'd1) begin
                    burst_on <= 1'b0;   // addr gen advances now, next size a cycle later
                end
                if (state == HEADER) begin
                    hdr_idx <= hdr_idx + 1'b1;
                end
            end
            if (issue) begin
                beat_valid_q <= 1'b1;
            end else if (beat.ready) begin
                beat_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus.load) begin
            pkt_words_q   <= i_pkt_words;
            seconds_q     <= i_seconds;     // timestamp taken at start
            nanoseconds_q <= i_nanoseconds;
        end
        if (size_hdr || size_pay) begin
            burst_len <= next_len;
        end
        if (issue) begin
            beat_addr_q <= bus.addr;
            beat_bcnt_q <= burst_len;
            hdr_word_q  <= hdr_word;
            from_fifo_q <= (state == PAYLOAD);
        end
    end

endmodule

`default_nettype wire

// ==== cap_writer_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module cap_writer_top import cap_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  cap_word_t i_pkt_data,
    input  logic      i_pkt_push,
    input  logic      i_start,
    input  cap_len_t  i_pkt_words,
    input  cap_addr_t i_buf_start,
    input  cap_addr_t i_buf_size,
    input  cap_word_t i_seconds,
    input  cap_word_t i_nanoseconds,
    input  logic      i_waitrequest,
    output logic      o_fifo_full,
    output logic      o_done,
    output logic      o_buf_wrap,
    output cap_addr_t o_last_write_addr,
    output cap_addr_t o_address,
    output cap_word_t o_writedata,
    output logic      o_write,
    output cap_bcnt_t o_burstcount
);

    cap_word_t  fifo_data;
    cap_level_t fifo_level;
    logic       fifo_rd;
    logic       fifo_empty;
    logic       beat_accept;

    cap_burst_if burst_bus ();
    cap_beat_if  ctrl_beat ();  // fsm to first skid buffer
    cap_beat_if  mid_beat ();
    cap_beat_if  av_beat ();    // avalon master side

    assign av_beat.ready = !i_waitrequest;
    assign o_write       = av_beat.valid;
    assign o_address     = av_beat.address;
    assign o_burstcount  = av_beat.burstcount;
    assign o_writedata   = av_beat.data;
    assign beat_accept   = o_write && !i_waitrequest;

    cap_word_fifo fifo_i (
        .clk     (clk),
        .reset   (reset),
        .i_push  (i_pkt_push),
        .i_data  (i_pkt_data),
        .i_pop   (fifo_rd),
        .o_data  (fifo_data),
        .o_empty (fifo_empty),
        .o_full  (o_fifo_full),
        .o_level (fifo_level)
    );

    cap_wr_ctrl ctrl_i (
        .clk           (clk),
        .reset         (reset),
        .i_start       (i_start),
        .i_pkt_words   (i_pkt_words),
        .i_buf_start   (i_buf_start),
        .i_buf_size    (i_buf_size),
        .i_seconds     (i_seconds),
        .i_nanoseconds (i_nanoseconds),
        .i_fifo_data   (fifo_data),
        .i_fifo_empty  (fifo_empty),
        .i_fifo_level  (fifo_level),
        .o_fifo_rd     (fifo_rd),
        .o_done        (o_done),
        .bus           (burst_bus.ctrl),
        .beat          (ctrl_beat.src),
        .i_beat_accept (beat_accept)
    );

    cap_addr_gen addr_i (
        .clk               (clk),
        .reset             (reset),
        .bus               (burst_bus.gen),
        .o_buf_wrap        (o_buf_wrap),
        .o_last_write_addr (o_last_write_addr)
    );

    cap_skid_buf skid1_i (
        .clk      (clk),
        .reset    (reset),
        .in_beat  (ctrl_beat.snk),
        .out_beat (mid_beat.src)
    );

    cap_skid_buf skid2_i (
        .clk      (clk),
        .reset    (reset),
        .in_beat  (mid_beat.snk),
        .out_beat (av_beat.src)
    );

endmodule

`default_nettype wire
